// File: verilog.f
src/tsc_pkg.sv
src/alu.sv
src/register_file.sv
src/control_fsm.sv
src/datapath.sv
src/access_timer.sv
src/unified_memory.sv
src/cpu.sv
src/tsc_system.sv
bench/tb_tsc_system.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = tb_tsc_system
RTL_TOP    = tsc_system
FILE_LIST  = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_tsc_system.sv
`timescale 1ns/1ps

module tb_tsc_system;

	localparam int          TIMEOUT     = 5000;
	localparam int          HOLD_CYCLES = 50;
	localparam logic [15:0] POISON      = 16'h005a;

	logic        Clk;
	logic        rst_n;
	logic        load_en;
	logic [15:0] load_addr;
	logic [15:0] load_data;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic        output_valid;
	logic        is_halted;

	logic [15:0] prog [256];
	int          prog_len;
	logic [15:0] exp_q [$];
	logic [15:0] got_q [$];
	int          exp_count;
	int          error_count;
	int          check_count;

	tsc_system uut (
		.Clk(Clk),
		.rst_n(rst_n),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid),
		.is_halted(is_halted)
	);

	always #4 Clk = ~Clk;

	function automatic logic [15:0] rtype_word(input logic [1:0] rs, input logic [1:0] rt,
		input logic [1:0] rd, input logic [5:0] func);
		return {4'd15, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] itype_word(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jump_word(input logic [11:0] target);
		return {4'd9, target};
	endfunction

	task automatic append_word(input logic [15:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic compare_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_idle(input string when_txt);
		compare_word({"num_inst ", when_txt}, num_inst, 16'h0000);
		compare_word({"output_port ", when_txt}, output_port, 16'h0000);
		compare_word({"output_valid ", when_txt}, {15'b0, output_valid}, 16'h0000);
		compare_word({"is_halted ", when_txt}, {15'b0, is_halted}, 16'h0000);
	endtask

	// Instruction-level reference of the ISA, one step per instruction
	task automatic run_model();
		logic [15:0] mem [256];
		logic [15:0] regs [4];
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] imm;
		logic [15:0] addr;
		logic [1:0]  rs;
		logic [1:0]  rt;
		logic [1:0]  rd;
		bit          done;
		int          steps;
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i < prog_len) ? prog[i] : 16'h0000;
		end
		for (int i = 0; i < 4; i++) begin
			regs[i] = 16'h0000;
		end
		pc = 16'h0000;
		done = 1'b0;
		steps = 0;
		exp_q.delete();
		exp_count = 0;
		while (!done && steps < 4000) begin
			ir = mem[pc[7:0]];
			pc = pc + 16'd1;
			rs = ir[11:10];
			rt = ir[9:8];
			rd = ir[7:6];
			imm = {{8{ir[7]}}, ir[7:0]};
			addr = regs[rs] + imm;
			case (ir[15:12])
				4'd15: begin
					case (ir[5:0])
						6'd0: regs[rd] = regs[rs] + regs[rt];
						6'd1: regs[rd] = regs[rs] - regs[rt];
						6'd2: regs[rd] = regs[rs] & regs[rt];
						6'd3: regs[rd] = regs[rs] | regs[rt];
						6'd28: exp_q.push_back(regs[rs]);
						6'd29: done = 1'b1;
						default: ;
					endcase
				end
				4'd4: regs[rt] = addr;
				4'd7: regs[rt] = mem[addr[7:0]];
				4'd8: mem[addr[7:0]] = regs[rt];
				4'd0: if (regs[rs] != regs[rt]) pc = pc + imm;
				4'd1: if (regs[rs] == regs[rt]) pc = pc + imm;
				4'd9: pc = {pc[15:12], ir[11:0]};
				default: ;
			endcase
			exp_count++;
			steps++;
		end
		if (!done) begin
			$display("Reference model never reached HLT");
			error_count++;
		end
	endtask

	// Program goes in while the core is held in reset
	task automatic reset_core(input bit reload);
		int cycles;
		cycles = (reload && prog_len > 4) ? prog_len : 4;
		for (int i = 0; i < cycles; i++) begin
			@(posedge Clk);
			rst_n <= 1'b0;
			load_en <= reload && (i < prog_len);
			load_addr <= 16'(i);
			load_data <= prog[i];
		end
		@(negedge Clk);
		check_idle("in reset");
		@(posedge Clk);
		rst_n <= 1'b1;
		load_en <= 1'b0;
		@(negedge Clk);
		check_idle("after reset");
	endtask

	task automatic execute_program(input bit reload);
		int cycles;
		int n;
		run_model();
		reset_core(reload);
		got_q.delete();
		cycles = 0;
		while (!is_halted && cycles < TIMEOUT) begin
			@(negedge Clk);
			if (output_valid) begin
				got_q.push_back(output_port);
			end
			cycles++;
		end
		if (!is_halted) begin
			$display("Timeout: core did not halt within %0d cycles", TIMEOUT);
			error_count++;
		end else begin
			compare_word("output_valid count", 16'(got_q.size()), 16'(exp_q.size()));
			n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
			for (int i = 0; i < n; i++) begin
				compare_word("output_port", got_q[i], exp_q[i]);
			end
			compare_word("num_inst", num_inst, 16'(exp_count));
			// Halted core must stay quiet
			for (int i = 0; i < HOLD_CYCLES; i++) begin
				@(negedge Clk);
				if (!is_halted) begin
					$display("is_halted dropped at %0t after HLT", $time);
					error_count++;
				end
				if (output_valid) begin
					$display("output_valid pulsed at %0t after HLT", $time);
					error_count++;
				end
			end
			compare_word("num_inst after halt", num_inst, 16'(exp_count));
		end
	endtask

	task automatic reset_state_test();
		prog_len = 0;
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_HLT));
		execute_program(1'b1);
	endtask

	task automatic arithmetic_test();
		logic [7:0] i1;
		logic [7:0] i2;
		logic [7:0] i3;
		i1 = 8'($urandom());
		i2 = 8'($urandom());
		i3 = 8'($urandom());
		prog_len = 0;
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd1, i1));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd2, i2));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd1, 2'd3, i3));
		append_word(rtype_word(2'd2, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd1, 2'd2, 2'd3, tsc_pkg::FN_ADD));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd1, 2'd2, 2'd3, tsc_pkg::FN_SUB));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd1, 2'd3, 2'd0, tsc_pkg::FN_AND));
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd0, 2'd2, 2'd3, tsc_pkg::FN_ORR));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd2, 2'd1, 2'd1, tsc_pkg::FN_SUB));
		append_word(rtype_word(2'd1, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_HLT));
		execute_program(1'b1);
	endtask

	task automatic memory_test();
		logic [7:0] v1;
		logic [7:0] v2;
		v1 = 8'($urandom());
		v2 = 8'($urandom());
		prog_len = 0;
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd1, v1));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd2, v2));
		append_word(itype_word(tsc_pkg::OP_SWD, 2'd0, 2'd1, 8'h40));
		append_word(itype_word(tsc_pkg::OP_SWD, 2'd0, 2'd2, 8'h41));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd1, 8'h00));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd2, 8'h00));
		append_word(itype_word(tsc_pkg::OP_LWD, 2'd0, 2'd3, 8'h40));
		append_word(itype_word(tsc_pkg::OP_LWD, 2'd0, 2'd1, 8'h41));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd1, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_HLT));
		execute_program(1'b1);
		if (got_q.size() == 2) begin
			compare_word("output_port (word 0x40)", got_q[0], {{8{v1[7]}}, v1});
			compare_word("output_port (word 0x41)", got_q[1], {{8{v2[7]}}, v2});
		end
		// Second run from the same memory image, no reload
		execute_program(1'b0);
	endtask

	task automatic branch_test();
		prog_len = 0;
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd1, 8'd5));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd2, 8'd1));
		append_word(rtype_word(2'd1, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd1, 2'd2, 2'd1, tsc_pkg::FN_SUB));
		append_word(itype_word(tsc_pkg::OP_BNE, 2'd1, 2'd0, 8'hfd));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd3, POISON[7:0]));
		append_word(itype_word(tsc_pkg::OP_BEQ, 2'd1, 2'd0, 8'd1));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(jump_word(12'd10));
		append_word(rtype_word(2'd3, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		// Unassigned opcode
		append_word(16'h2000);
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd1, 8'd7));
		append_word(rtype_word(2'd1, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_HLT));
		execute_program(1'b1);
		foreach (got_q[i]) begin
			if (got_q[i] == POISON) begin
				$display("Skipped WWD ran at %0t, output_port showed %h", $time, got_q[i]);
				error_count++;
			end
		end
	endtask

	task automatic halt_test();
		prog_len = 0;
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd0, 2'd2, 8'($urandom())));
		append_word(rtype_word(2'd2, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(16'h3000);
		append_word(rtype_word(2'd0, 2'd0, 2'd0, tsc_pkg::FN_HLT));
		append_word(rtype_word(2'd2, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		append_word(itype_word(tsc_pkg::OP_ADI, 2'd2, 2'd2, 8'd1));
		append_word(rtype_word(2'd2, 2'd0, 2'd0, tsc_pkg::FN_WWD));
		execute_program(1'b1);
	endtask

	initial begin
		Clk = 1'b0;
		rst_n = 1'b0;
		load_en = 1'b0;
		load_addr = 16'h0000;
		load_data = 16'h0000;
		error_count = 0;
		check_count = 0;
		prog_len = 0;
		void'($urandom(32'hc0fc));
		reset_state_test();
		arithmetic_test();
		memory_test();
		branch_test();
		halt_test();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: src/tsc_system.sv
`timescale 1ns/1ps

module tsc_system #(
	parameter int MEM_DEPTH   = 256,
	parameter int MEM_LATENCY = 3
) (
	input  logic                          Clk,
	input  logic                          rst_n,
	input  logic                          load_en,
	input  logic [tsc_pkg::WORD_SIZE-1:0] load_addr,
	input  logic [tsc_pkg::WORD_SIZE-1:0] load_data,
	output logic [tsc_pkg::WORD_SIZE-1:0] num_inst,
	output logic [tsc_pkg::WORD_SIZE-1:0] output_port,
	output logic                          output_valid,
	output logic                          is_halted
);

	tsc_pkg::mem_req_t mem_req;
	tsc_pkg::mem_rsp_t mem_rsp;

	cpu u_cpu (
		.Clk(Clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid),
		.is_halted(is_halted)
	);

	// One memory serves fetch and data
	unified_memory #(
		.MEM_DEPTH(MEM_DEPTH),
		.MEM_LATENCY(MEM_LATENCY)
	) u_mem (
		.Clk(Clk),
		.rst_n(rst_n),
		.req(mem_req),
		.rsp(mem_rsp),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

// File: src/cpu.sv
`timescale 1ns/1ps

module cpu (
	input  logic                          Clk,
	input  logic                          rst_n,
	output tsc_pkg::mem_req_t             mem_req,
	input  tsc_pkg::mem_rsp_t             mem_rsp,
	output logic [tsc_pkg::WORD_SIZE-1:0] num_inst,
	output logic [tsc_pkg::WORD_SIZE-1:0] output_port,
	output logic                          output_valid,
	output logic                          is_halted
);

	tsc_pkg::ctrl_t   ctrl;
	tsc_pkg::decode_t dec;
	logic             req_read;
	logic             req_write;

	control_fsm u_fsm (
		.Clk(Clk),
		.rst_n(rst_n),
		.dec(dec),
		.ctrl(ctrl),
		.req_read(req_read),
		.req_write(req_write),
		.halted(is_halted)
	);

	datapath u_dp (
		.Clk(Clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.req_read(req_read),
		.req_write(req_write),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.dec(dec),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid)
	);

endmodule

// File: src/unified_memory.sv
`timescale 1ns/1ps

module unified_memory #(
	parameter int MEM_DEPTH   = 256,
	parameter int MEM_LATENCY = 3
) (
	input  logic                          Clk,
	input  logic                          rst_n,
	input  tsc_pkg::mem_req_t             req,
	output tsc_pkg::mem_rsp_t             rsp,
	input  logic                          load_en,
	input  logic [tsc_pkg::WORD_SIZE-1:0] load_addr,
	input  logic [tsc_pkg::WORD_SIZE-1:0] load_data
);

	localparam int AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	logic [tsc_pkg::WORD_SIZE-1:0] mem [MEM_DEPTH];
	logic [AW-1:0]                 req_idx;
	logic [AW-1:0]                 load_idx;
	logic                          ack;

	access_timer #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_timer (
		.Clk(Clk),
		.rst_n(rst_n),
		.start(req.read || req.write),
		.done(ack)
	);

	// Addresses wrap at the array depth
	assign req_idx = AW'(req.addr % tsc_pkg::WORD_SIZE'(MEM_DEPTH));
	assign load_idx = AW'(load_addr % tsc_pkg::WORD_SIZE'(MEM_DEPTH));

	assign rsp.ack = ack;
	assign rsp.rdata = mem[req_idx];

	// Load port works in or out of reset
	always_ff @(posedge Clk) begin
		if (load_en) begin
			mem[load_idx] <= load_data;
		end else if (ack && req.write) begin
			mem[req_idx] <= req.wdata;
		end
	end

endmodule

// File: src/access_timer.sv
`timescale 1ns/1ps

module access_timer #(
	parameter int MEM_LATENCY = 3
) (
	input  logic Clk,
	input  logic rst_n,
	input  logic start,
	output logic done
);

	localparam int CW = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	logic [CW-1:0] count;

	// Fires in the MEM_LATENCY-th cycle of a request
	assign done = start && (count == CW'(MEM_LATENCY - 1));

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!start || done) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: src/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic                          Clk,
	input  logic                          rst_n,
	input  tsc_pkg::ctrl_t                ctrl,
	input  logic                          req_read,
	input  logic                          req_write,
	output tsc_pkg::mem_req_t             mem_req,
	input  tsc_pkg::mem_rsp_t             mem_rsp,
	output tsc_pkg::decode_t              dec,
	output logic [tsc_pkg::WORD_SIZE-1:0] num_inst,
	output logic [tsc_pkg::WORD_SIZE-1:0] output_port,
	output logic                          output_valid
);

	logic [tsc_pkg::WORD_SIZE-1:0] pc;
	logic [tsc_pkg::WORD_SIZE-1:0] ir;
	logic [tsc_pkg::WORD_SIZE-1:0] op_a;
	logic [tsc_pkg::WORD_SIZE-1:0] op_b;
	logic [tsc_pkg::WORD_SIZE-1:0] alu_result;
	logic [tsc_pkg::WORD_SIZE-1:0] mdr;
	logic [tsc_pkg::WORD_SIZE-1:0] imm_ext;
	logic [tsc_pkg::WORD_SIZE-1:0] alu_b;
	logic [tsc_pkg::WORD_SIZE-1:0] alu_y;
	logic [tsc_pkg::WORD_SIZE-1:0] rd1;
	logic [tsc_pkg::WORD_SIZE-1:0] rd2;
	logic [tsc_pkg::WORD_SIZE-1:0] wb_data;
	logic [tsc_pkg::WORD_SIZE-1:0] resolved_pc;
	logic [1:0]                    wr_addr;
	logic                          taken;
	logic                          is_wwd;

	assign dec.opcode = tsc_pkg::opcode_t'(ir[15:12]);
	assign dec.func = tsc_pkg::func_t'(ir[5:0]);
	assign dec.last_ack = mem_rsp.ack;

	assign imm_ext = {{8{ir[7]}}, ir[7:0]};
	assign alu_b = ctrl.alu_src_imm ? imm_ext : op_b;
	assign wr_addr = ctrl.dest_rt ? ir[9:8] : ir[7:6];
	assign wb_data = ctrl.wb_sel_mem ? mdr : alu_result;
	assign is_wwd = dec.opcode == tsc_pkg::OP_RTYPE && dec.func == tsc_pkg::FN_WWD;

	alu u_alu (
		.a(op_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.y(alu_y)
	);

	register_file u_regs (
		.Clk(Clk),
		.rst_n(rst_n),
		.rs(ir[11:10]),
		.rt(ir[9:8]),
		.wr_addr(wr_addr),
		.wr_data(wb_data),
		.wr_en(ctrl.reg_write),
		.rd1(rd1),
		.rd2(rd2)
	);

	// pc already holds pc + 1 here
	always_comb begin
		case (dec.opcode)
			tsc_pkg::OP_BNE: taken = op_a != op_b;
			tsc_pkg::OP_BEQ: taken = op_a == op_b;
			tsc_pkg::OP_JMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		if (dec.opcode == tsc_pkg::OP_JMP) begin
			resolved_pc = {pc[tsc_pkg::WORD_SIZE-1 -: 4], ir[11:0]};
		end else begin
			resolved_pc = pc + imm_ext;
		end
	end

	assign mem_req.read = req_read;
	assign mem_req.write = req_write;
	assign mem_req.addr = ctrl.mem_sel ? alu_result : pc;
	assign mem_req.wdata = op_b;

	always_ff @(posedge Clk) begin
		if (ctrl.ir_load) begin
			ir <= mem_rsp.rdata;
		end
		if (ctrl.operand_load) begin
			op_a <= rd1;
			op_b <= rd2;
		end
		if (mem_rsp.ack) begin
			mdr <= mem_rsp.rdata;
		end
		// Operands hold still, so this stays valid through memory and write-back
		alu_result <= alu_y;
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			pc <= '0;
			num_inst <= '0;
			output_port <= '0;
			output_valid <= 1'b0;
		end else begin
			if (ctrl.pc_inc) begin
				pc <= pc + 1'b1;
			end else if (ctrl.pc_resolve && taken) begin
				pc <= resolved_pc;
			end
			if (ctrl.retire) begin
				num_inst <= num_inst + 1'b1;
			end
			if (ctrl.retire && is_wwd) begin
				output_port <= op_a;
			end
			output_valid <= ctrl.retire && is_wwd;
		end
	end

endmodule

// File: src/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
	input  logic              Clk,
	input  logic              rst_n,
	input  tsc_pkg::decode_t  dec,
	output tsc_pkg::ctrl_t    ctrl,
	output logic              req_read,
	output logic              req_write,
	output logic              halted
);

	tsc_pkg::state_t state;
	tsc_pkg::state_t next_state;
	logic            is_rtype;
	logic            is_mem;
	logic            is_hlt;
	logic            writes_reg;

	assign is_rtype = dec.opcode == tsc_pkg::OP_RTYPE;
	assign is_mem = dec.opcode == tsc_pkg::OP_LWD || dec.opcode == tsc_pkg::OP_SWD;
	assign is_hlt = is_rtype && dec.func == tsc_pkg::FN_HLT;
	assign writes_reg = dec.opcode == tsc_pkg::OP_ADI ||
		(is_rtype && dec.func inside {tsc_pkg::FN_ADD, tsc_pkg::FN_SUB,
		tsc_pkg::FN_AND, tsc_pkg::FN_ORR});
	assign halted = state == tsc_pkg::HALT;

	always_comb begin
		ctrl = '0;
		next_state = state;
		// ALU setup follows the instruction, not the state
		ctrl.alu_op = tsc_pkg::ALU_PASS_A;
		if (dec.opcode inside {tsc_pkg::OP_ADI, tsc_pkg::OP_LWD, tsc_pkg::OP_SWD}) begin
			ctrl.alu_op = tsc_pkg::ALU_ADD;
			ctrl.alu_src_imm = 1'b1;
		end else if (is_rtype) begin
			case (dec.func)
				tsc_pkg::FN_ADD: ctrl.alu_op = tsc_pkg::ALU_ADD;
				tsc_pkg::FN_SUB: ctrl.alu_op = tsc_pkg::ALU_SUB;
				tsc_pkg::FN_AND: ctrl.alu_op = tsc_pkg::ALU_AND;
				tsc_pkg::FN_ORR: ctrl.alu_op = tsc_pkg::ALU_OR;
				default: ctrl.alu_op = tsc_pkg::ALU_PASS_A;
			endcase
		end
		case (state)
			tsc_pkg::FETCH: begin
				ctrl.ir_load = dec.last_ack;
				ctrl.pc_inc = dec.last_ack;
				if (dec.last_ack) begin
					next_state = tsc_pkg::DECODE;
				end
			end
			tsc_pkg::DECODE: begin
				ctrl.operand_load = 1'b1;
				next_state = tsc_pkg::EXECUTE;
			end
			tsc_pkg::EXECUTE: begin
				if (is_mem) begin
					next_state = tsc_pkg::MEMORY;
				end else if (writes_reg) begin
					next_state = tsc_pkg::WRITEBACK;
				end else begin
					// Branches, jumps, WWD, HLT and no-ops end here
					ctrl.pc_resolve = 1'b1;
					ctrl.retire = 1'b1;
					next_state = is_hlt ? tsc_pkg::HALT : tsc_pkg::FETCH;
				end
			end
			tsc_pkg::MEMORY: begin
				ctrl.mem_sel = 1'b1;
				if (dec.last_ack) begin
					ctrl.retire = dec.opcode == tsc_pkg::OP_SWD;
					next_state = (dec.opcode == tsc_pkg::OP_SWD) ? tsc_pkg::FETCH :
						tsc_pkg::WRITEBACK;
				end
			end
			tsc_pkg::WRITEBACK: begin
				ctrl.reg_write = 1'b1;
				ctrl.retire = 1'b1;
				ctrl.wb_sel_mem = dec.opcode == tsc_pkg::OP_LWD;
				ctrl.dest_rt = !is_rtype;
				next_state = tsc_pkg::FETCH;
			end
			tsc_pkg::HALT: begin
				next_state = tsc_pkg::HALT;
			end
			default: begin
				next_state = tsc_pkg::FETCH;
			end
		endcase
	end

	// Requests drop for at least one cycle after every ack
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			state <= tsc_pkg::FETCH;
			req_read <= 1'b0;
			req_write <= 1'b0;
		end else begin
			state <= next_state;
			req_read <= !dec.last_ack && (next_state == tsc_pkg::FETCH ||
				(next_state == tsc_pkg::MEMORY && dec.opcode == tsc_pkg::OP_LWD));
			req_write <= !dec.last_ack && next_state == tsc_pkg::MEMORY &&
				dec.opcode == tsc_pkg::OP_SWD;
		end
	end

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                          Clk,
	input  logic                          rst_n,
	input  logic [1:0]                    rs,
	input  logic [1:0]                    rt,
	input  logic [1:0]                    wr_addr,
	input  logic [tsc_pkg::WORD_SIZE-1:0] wr_data,
	input  logic                          wr_en,
	output logic [tsc_pkg::WORD_SIZE-1:0] rd1,
	output logic [tsc_pkg::WORD_SIZE-1:0] rd2
);

	logic [tsc_pkg::WORD_SIZE-1:0] regs [4];

	// Programs may assume zeroed registers
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd1 = regs[rs];
	assign rd2 = regs[rt];

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [tsc_pkg::WORD_SIZE-1:0] a,
	input  logic [tsc_pkg::WORD_SIZE-1:0] b,
	input  tsc_pkg::alu_op_t              op,
	output logic [tsc_pkg::WORD_SIZE-1:0] y
);

	always_comb begin
		case (op)
			tsc_pkg::ALU_ADD: begin
				y = a + b;
			end
			tsc_pkg::ALU_SUB: begin
				y = a - b;
			end
			tsc_pkg::ALU_AND: begin
				y = a & b;
			end
			tsc_pkg::ALU_OR: begin
				y = a | b;
			end
			// Pass-A also covers unused encodings
			default: begin
				y = a;
			end
		endcase
	end

endmodule

// File: src/tsc_pkg.sv
package tsc_pkg;

	localparam int WORD_SIZE = 16;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_RTYPE = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_A
	} alu_op_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK,
		HALT
	} state_t;

	typedef struct packed {
		logic                 read;
		logic                 write;
		logic [WORD_SIZE-1:0] addr;
		logic [WORD_SIZE-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic                 ack;
		logic [WORD_SIZE-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic    ir_load;
		logic    pc_inc;
		logic    operand_load;
		alu_op_t alu_op;
		logic    alu_src_imm;
		logic    pc_resolve;
		logic    mem_sel;
		logic    reg_write;
		logic    wb_sel_mem;
		logic    dest_rt;
		logic    retire;
	} ctrl_t;

	typedef struct packed {
		opcode_t opcode;
		func_t   func;
		logic    last_ack;
	} decode_t;

endpackage
